//--- csr_exec.sv
// Zicsr exec stage: instruction decode, read-only check and three-state FSM
// Produces the rd write-back and the CSR write request
`timescale 1ns/100ps

module csr_exec import csr_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    // Instruction port
    input  logic              valid,
    output logic              ready,
    input  logic [INST_W-1:0] instbus,
    // rs1 query
    output reg_addr_t         rs1_addr,
    input  xlen_t             rs1_val,
    // rd write-back
    output logic              rd_wr_en,
    output reg_addr_t         rd_wr_addr,
    output xlen_t             rd_wr_val,
    output logic              ro_trap,
    // Register file side
    output csr_wr_t           csr_wr,
    output csr_addr_t         csr_rd_addr,
    input  xlen_t             csr_rd_data
);

    exec_state_e state;

    // Raw instruction fields
    csr_op_e   op;
    csr_addr_t csr_f;
    reg_addr_t rs1_f;       // rs1 index or zimm
    reg_addr_t rd_f;

    // Captured on accept
    csr_op_e   op_r;
    csr_addr_t csr_r;
    reg_addr_t rs1_r;
    xlen_t     rs1_val_r;

    logic      is_write;    // Instruction would modify the CSR
    logic      ro_access;   // Write into the read-only space
    logic      accept;
    xlen_t     src;
    xlen_t     new_val;
    xlen_t     new_val_q;
    logic      do_write;
    logic      wr_en;

    // ---------------------------------------------------------------------
    // Decode and legality
    // ---------------------------------------------------------------------

    assign op    = csr_op_e'(instbus[FUNCT3_LSB +: FUNCT3_W]);
    assign csr_f = instbus[CSR_LSB +: CSR_ADDR_W];
    assign rs1_f = instbus[RS1_LSB +: REG_ADDR_W];
    assign rd_f  = instbus[RD_LSB +: REG_ADDR_W];

    assign rs1_addr = rs1_f;    // Straight to the integer register file

    always_comb begin
        case (op)
            CSRRW, CSRRWI:                 is_write = 1'b1;
            CSRRS, CSRRC, CSRRSI, CSRRCI:  is_write = (rs1_f != '0);  // x0 / zimm 0 only reads
            default:                       is_write = 1'b0;
        endcase
    end

    // Top two address bits set marks read-only space
    assign ro_access = (csr_f[11:10] == 2'b11) && is_write;

    assign ready  = (state == IDLE);
    assign accept = ready && valid && !ro_access;

    // ---------------------------------------------------------------------
    // New value, evaluated while in COMPUTE
    // ---------------------------------------------------------------------

    assign csr_rd_addr = csr_r;

    always_comb begin
        // Immediate forms take zimm, zero-extended
        if (op_r inside {CSRRWI, CSRRSI, CSRRCI})
            src = {{(XLEN-REG_ADDR_W){1'b0}}, rs1_r};
        else
            src = rs1_val_r;

        new_val  = csr_rd_data;
        do_write = 1'b0;
        case (op_r)
            CSRRW, CSRRWI: begin
                new_val  = src;                 // Swap
                do_write = 1'b1;
            end
            CSRRS, CSRRSI: begin
                new_val  = csr_rd_data | src;   // Set bits
                do_write = (rs1_r != '0);
            end
            CSRRC, CSRRCI: begin
                new_val  = csr_rd_data & ~src;  // Clear bits
                do_write = (rs1_r != '0);
            end
            default: ;                          // Unknown funct3 only reads
        endcase
    end

    // ---------------------------------------------------------------------
    // FSM and strobes
    // ---------------------------------------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            rd_wr_en <= 1'b0;
            wr_en    <= 1'b0;
            ro_trap  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (valid && ro_access) begin
                        ro_trap <= 1'b1;        // Held until next legal accept
                    end else if (accept) begin
                        ro_trap <= 1'b0;
                        state   <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    rd_wr_en <= 1'b1;           // Old value always goes to rd
                    wr_en    <= do_write;
                    state    <= STORE;
                end
                STORE: begin
                    rd_wr_en <= 1'b0;
                    wr_en    <= 1'b0;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge aclk) begin
        if (accept) begin
            op_r       <= op;
            csr_r      <= csr_f;
            rs1_r      <= rs1_f;
            rs1_val_r  <= rs1_val;
            rd_wr_addr <= rd_f;
        end
        if (state == COMPUTE) begin
            rd_wr_val <= csr_rd_data;
            new_val_q <= new_val;
        end
    end

    assign csr_wr = '{en: wr_en, addr: csr_r, data: new_val_q};

    // ---------------------------------------------------------------------
    // Assertions
    // ---------------------------------------------------------------------

    a_rd_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr_en |=> !rd_wr_en)
        else $error("rd_wr_en high two cycles in a row");

    a_wr_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        csr_wr.en |-> state != IDLE)
        else $error("CSR write strobe while FSM idle");

endmodule

//--- csr_pkg.sv
// Shared widths, CSR addresses, instruction field offsets and legal masks
// Enums and packed structs passed between the exec stage and the register file
package csr_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------

    localparam int XLEN       = 32;   // Machine word width
    localparam int INST_W     = 32;   // Instruction bus width
    localparam int REG_ADDR_W = 5;    // Integer register index, also zimm
    localparam int CSR_ADDR_W = 12;   // CSR address space
    localparam int FUNCT3_W   = 3;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // ---------------------------------------------------------------------
    // Instruction field positions (I-type layout)
    // ---------------------------------------------------------------------

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;   // rs1 index or zimm
    localparam int CSR_LSB    = 20;

    // ---------------------------------------------------------------------
    // Machine-mode CSR addresses
    // ---------------------------------------------------------------------

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;   // Read-only here
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

    // ---------------------------------------------------------------------
    // Fixed values and legal field masks
    // ---------------------------------------------------------------------

    // MXL=1 (RV32) in the top two bits, I extension at bit 8
    localparam xlen_t MISA_VALUE = 32'h4000_0100;

    // Writable mstatus fields, WPRI bits read as zero
    //   bit 31, bits 22:11, bits 8:7, bits 5:3, bits 1:0
    localparam xlen_t MSTATUS_MASK = 32'h807F_F9BB;

    // ---------------------------------------------------------------------
    // Enums
    // ---------------------------------------------------------------------

    // Zicsr funct3 encodings
    typedef enum logic [FUNCT3_W-1:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_op_e;

    // Exec stage FSM
    typedef enum logic [1:0] {
        IDLE,       // Waiting for an instruction
        COMPUTE,    // Old value read, new value formed
        STORE       // Register file takes the write
    } exec_state_e;

    // ---------------------------------------------------------------------
    // Structs
    // ---------------------------------------------------------------------

    // CSR write request, exec stage to register file (45 bits)
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // Shared bus of CSRs used across the core (96 bits)
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mstatus;
    } csr_sb_t;

endpackage

//--- csr_regfile.sv
// Machine-mode CSR storage with legal-field masking and mepc alignment
// Combinational read mux and the shared CSR bus
`timescale 1ns/100ps

module csr_regfile import csr_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    // From exec stage
    input  csr_wr_t   csr_wr,
    input  csr_addr_t csr_rd_addr,
    output xlen_t     csr_rd_data,
    // Direct writes from the core
    input  logic      ctrl_mepc_wr,
    input  xlen_t     ctrl_mepc,
    input  logic      ctrl_mstatus_wr,
    input  xlen_t     ctrl_mstatus,
    // Shared bus
    output csr_sb_t   csr_sb
);

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;

    // IALIGN=32, two low bits never stored
    function automatic xlen_t align_pc(input xlen_t pc);
        return {pc[XLEN-1:2], 2'b00};
    endfunction

    // ---------------------------------------------------------------------
    // Registers with an external writer
    // ---------------------------------------------------------------------

    // mstatus, WPRI fields dropped on every source
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus <= '0;
        end else if (ctrl_mstatus_wr) begin
            mstatus <= ctrl_mstatus & MSTATUS_MASK;     // Core wins
        end else if (csr_wr.en && csr_wr.addr == CSR_MSTATUS) begin
            mstatus <= csr_wr.data & MSTATUS_MASK;
        end
    end

    // mepc
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mepc <= '0;
        end else if (ctrl_mepc_wr) begin
            mepc <= align_pc(ctrl_mepc);                // Core wins
        end else if (csr_wr.en && csr_wr.addr == CSR_MEPC) begin
            mepc <= align_pc(csr_wr.data);
        end
    end

    // ---------------------------------------------------------------------
    // Plain read/write registers
    // ---------------------------------------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mtvec    <= '0;
            mscratch <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                CSR_MTVEC:    mtvec    <= csr_wr.data;
                CSR_MSCRATCH: mscratch <= csr_wr.data;
                CSR_MCAUSE:   mcause   <= csr_wr.data;
                CSR_MTVAL:    mtval    <= csr_wr.data;
                default: ;      // misa and unimplemented addresses ignore writes
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // Read mux
    // ---------------------------------------------------------------------

    always_comb begin
        case (csr_rd_addr)
            CSR_MSTATUS:  csr_rd_data = mstatus;
            CSR_MISA:     csr_rd_data = MISA_VALUE;     // Constant
            CSR_MTVEC:    csr_rd_data = mtvec;
            CSR_MSCRATCH: csr_rd_data = mscratch;
            CSR_MEPC:     csr_rd_data = mepc;
            CSR_MCAUSE:   csr_rd_data = mcause;
            CSR_MTVAL:    csr_rd_data = mtval;
            default:      csr_rd_data = '0;             // Unimplemented
        endcase
    end

    // Shared bus to the rest of the core
    assign csr_sb = '{mtvec: mtvec, mepc: mepc, mstatus: mstatus};

    // ---------------------------------------------------------------------
    // Assertions
    // ---------------------------------------------------------------------

    // Also covers the bus copy seen by fetch
    a_mepc_align: assert property (@(posedge aclk) disable iff (!aresetn)
        csr_sb.mepc[1:0] == 2'b00)
        else $error("mepc holds a misaligned address");

endmodule

//--- csr_top.sv
// CSR unit top level
// Exec stage feeding the machine-mode register file
`timescale 1ns/100ps

module csr_top import csr_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    // Instruction port
    input  logic              valid,
    output logic              ready,
    input  logic [INST_W-1:0] instbus,
    // rs1 query
    output reg_addr_t         rs1_addr,
    input  xlen_t             rs1_val,
    // rd write-back
    output logic              rd_wr_en,
    output reg_addr_t         rd_wr_addr,
    output xlen_t             rd_wr_val,
    // Direct writes from the core
    input  logic              ctrl_mepc_wr,
    input  xlen_t             ctrl_mepc,
    input  logic              ctrl_mstatus_wr,
    input  xlen_t             ctrl_mstatus,
    // Status and shared bus
    output logic              ro_trap,
    output csr_sb_t           csr_sb
);

    csr_wr_t   csr_wr;          // Exec to regfile write request
    csr_addr_t csr_rd_addr;
    xlen_t     csr_rd_data;     // Combinational old value

    csr_exec u_exec (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .valid       (valid),
        .ready       (ready),
        .instbus     (instbus),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .rd_wr_en    (rd_wr_en),
        .rd_wr_addr  (rd_wr_addr),
        .rd_wr_val   (rd_wr_val),
        .ro_trap     (ro_trap),
        .csr_wr      (csr_wr),
        .csr_rd_addr (csr_rd_addr),
        .csr_rd_data (csr_rd_data)
    );

    csr_regfile u_regfile (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .csr_wr          (csr_wr),
        .csr_rd_addr     (csr_rd_addr),
        .csr_rd_data     (csr_rd_data),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .csr_sb          (csr_sb)
    );

endmodule

//--- project.f
+incdir+.
csr_pkg.sv
csr_exec.sv
csr_regfile.sv
csr_top.sv
tb_csr.sv

//--- run.sh
#!/bin/sh
# Compile and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_csr -Mdir "$OBJ" -o tb_csr
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/tb_csr" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- tb_csr_cases.svh
// Case table for the CSR unit testbench
// One row per instruction with its expected rd value, trap flag and shared bus
`ifndef TB_CSR_CASES_SVH
`define TB_CSR_CASES_SVH

// Columns: op, csr, rs1 or zimm, rd, rs1 value, mepc write, mepc,
//          mstatus write, mstatus, expected rd, expected trap, expected csr_sb
typedef struct packed {
    csr_op_e   op;
    csr_addr_t csr;
    reg_addr_t rs1;         // rs1 index or zimm
    reg_addr_t rd;
    xlen_t     rs1_val;
    logic      mepc_wr;     // Core write during the CSR write cycle
    xlen_t     mepc;
    logic      mstatus_wr;
    xlen_t     mstatus;
    xlen_t     exp_rd;
    logic      exp_trap;
    csr_sb_t   exp_sb;      // {mtvec, mepc, mstatus} after the row
} case_t;

localparam int NUM_CASES = 22;

case_t cases [NUM_CASES];

task automatic load_cases;
    // Swap on mscratch and mtvec
    cases[0]  = '{CSRRW,  CSR_MSCRATCH, 5'd1,  5'd5,  32'hDEAD_BEEF, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000}};
    cases[1]  = '{CSRRW,  CSR_MSCRATCH, 5'd2,  5'd6,  32'h1234_5678, 1'b0, '0, 1'b0, '0,
                  32'hDEAD_BEEF, 1'b0, '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000}};
    cases[2]  = '{CSRRW,  CSR_MTVEC,    5'd3,  5'd7,  32'h8000_0100, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h8000_0100, 32'h0000_0000, 32'h0000_0000}};
    cases[3]  = '{CSRRW,  CSR_MTVEC,    5'd4,  5'd8,  32'h0000_1004, 1'b0, '0, 1'b0, '0,
                  32'h8000_0100, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    // Set and clear on mcause, x0 only reads
    cases[4]  = '{CSRRS,  CSR_MCAUSE,   5'd9,  5'd10, 32'h8000_000B, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[5]  = '{CSRRC,  CSR_MCAUSE,   5'd11, 5'd12, 32'h8000_0000, 1'b0, '0, 1'b0, '0,
                  32'h8000_000B, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[6]  = '{CSRRS,  CSR_MCAUSE,   5'd0,  5'd13, 32'h0000_0000, 1'b0, '0, 1'b0, '0,
                  32'h0000_000B, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[7]  = '{CSRRC,  CSR_MCAUSE,   5'd0,  5'd14, 32'h0000_0000, 1'b0, '0, 1'b0, '0,
                  32'h0000_000B, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    // Immediate forms on mtval, rs1 file holds ones to catch a wrong source
    cases[8]  = '{CSRRWI, CSR_MTVAL,    5'd31, 5'd15, 32'hFFFF_FFFF, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[9]  = '{CSRRCI, CSR_MTVAL,    5'd5,  5'd16, 32'hFFFF_FFFF, 1'b0, '0, 1'b0, '0,
                  32'h0000_001F, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[10] = '{CSRRSI, CSR_MTVAL,    5'd1,  5'd17, 32'hFFFF_FFFF, 1'b0, '0, 1'b0, '0,
                  32'h0000_001A, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    cases[11] = '{CSRRCI, CSR_MTVAL,    5'd0,  5'd18, 32'h0000_0000, 1'b0, '0, 1'b0, '0,
                  32'h0000_001B, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h0000_0000}};
    // Legal-field masking
    cases[12] = '{CSRRW,  CSR_MSTATUS,  5'd20, 5'd21, 32'hFFFF_FFFF, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h0000_0000, 32'h807F_F9BB}};
    cases[13] = '{CSRRW,  CSR_MEPC,     5'd23, 5'd24, 32'h8000_0ABF, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    cases[14] = '{CSRRW,  CSR_MISA,     5'd26, 5'd27, 32'h1234_5678, 1'b0, '0, 1'b0, '0,
                  32'h4000_0100, 1'b0, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    cases[15] = '{CSRRS,  CSR_MISA,     5'd0,  5'd28, 32'h0000_0000, 1'b0, '0, 1'b0, '0,
                  32'h4000_0100, 1'b0, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    cases[16] = '{CSRRW,  12'h7C0,      5'd29, 5'd30, 32'hCAFE_F00D, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    // Read-only space
    cases[17] = '{CSRRW,  12'hC00,      5'd1,  5'd5,  32'h5555_5555, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b1, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    cases[18] = '{CSRRS,  12'hC00,      5'd0,  5'd6,  32'h0000_0000, 1'b0, '0, 1'b0, '0,
                  32'h0000_0000, 1'b0, '{32'h0000_1004, 32'h8000_0ABC, 32'h807F_F9BB}};
    // Core writes against a same-cycle CSR write
    cases[19] = '{CSRRW,  CSR_MEPC,     5'd2,  5'd7,  32'h0000_0200,
                  1'b1, 32'h0000_4007, 1'b0, '0, 32'h8000_0ABC, 1'b0,
                  '{32'h0000_1004, 32'h0000_4004, 32'h807F_F9BB}};
    cases[20] = '{CSRRW,  CSR_MSTATUS,  5'd3,  5'd8,  32'h0000_0008,
                  1'b0, '0, 1'b1, 32'hFFFF_0000, 32'h807F_F9BB, 1'b0,
                  '{32'h0000_1004, 32'h0000_4004, 32'h807F_0000}};
    cases[21] = '{CSRRS,  CSR_MSCRATCH, 5'd0,  5'd10, 32'h0000_0000,
                  1'b1, 32'h0000_0013, 1'b0, '0, 32'h1234_5678, 1'b0,
                  '{32'h0000_1004, 32'h0000_0010, 32'h807F_0000}};
endtask

`endif

//--- tb_csr.sv
// Testbench for the CSR unit with clock, reset and the case loop
// Compare tasks, cycle timeout and closing summary
`timescale 1ns/100ps

module tb_csr import csr_pkg::*; ();

    localparam int RESET_CYCLES = 8;

    logic              aclk;
    logic              aresetn;
    logic              valid;
    logic              ready;
    logic [INST_W-1:0] instbus;
    reg_addr_t         rs1_addr;
    xlen_t             rs1_val;
    logic              rd_wr_en;
    reg_addr_t         rd_wr_addr;
    xlen_t             rd_wr_val;
    logic              ctrl_mepc_wr;
    xlen_t             ctrl_mepc;
    logic              ctrl_mstatus_wr;
    xlen_t             ctrl_mstatus;
    logic              ro_trap;
    csr_sb_t           csr_sb;

    xlen_t rs1_file [32];           // Integer registers with x0 held at zero
    int    cycle_count = 0;
    int    errors;
    int    checks;
    string label;                   // Current case name for error lines

    `include "tb_csr_cases.svh"

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 6 * NUM_CASES + 50;

    csr_top dut (.*);

    assign rs1_val = rs1_file[rs1_addr];    // Combinational rs1 query

    always #10 aclk = ~aclk;                // 20 ns period

    // Run limit
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: t=%0t %s: %s got %h expected %h", $time, label, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: t=%0t %s: %s got %b expected %b", $time, label, what, got, exp);
        end
    endtask

    task automatic check_sb(input string what, input csr_sb_t got, input csr_sb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: t=%0t %s: %s got mtvec %h mepc %h mstatus %h", $time, label,
                     what, got.mtvec, got.mepc, got.mstatus);
            $display("error: t=%0t %s: %s expected mtvec %h mepc %h mstatus %h", $time,
                     label, what, exp.mtvec, exp.mepc, exp.mstatus);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------

    // SYSTEM opcode in the I-type layout
    function automatic logic [INST_W-1:0] encode_csr(input csr_op_e op, input csr_addr_t csr,
                                                     input reg_addr_t rs1, input reg_addr_t rd);
        return {csr, rs1, op, rd, 7'b1110011};
    endfunction

    task automatic wait_ready;
        @(negedge aclk);
        while (!ready) @(negedge aclk);
    endtask

    task automatic run_case(input int idx);
        case_t c;
        int    err_before;
        c          = cases[idx];
        err_before = errors;
        label      = $sformatf("case %0d", idx);
        wait_ready();
        @(posedge aclk);
        valid   <= 1'b1;
        instbus <= encode_csr(c.op, c.csr, c.rs1, c.rd);
        if (c.rs1 != '0) rs1_file[c.rs1] <= c.rs1_val;
        @(posedge aclk);                    // Accept edge or trap edge
        valid <= 1'b0;
        @(negedge aclk);
        check_word("rs1_addr", xlen_t'(rs1_addr), xlen_t'(c.rs1));
        check_bit("ro_trap", ro_trap, c.exp_trap);
        if (c.exp_trap) begin
            check_bit("ready", ready, 1'b1);    // Not accepted
            @(negedge aclk);
            check_bit("rd_wr_en", rd_wr_en, 1'b0);
        end else begin
            @(posedge aclk);                // CSR write cycle starts
            ctrl_mepc_wr    <= c.mepc_wr;
            ctrl_mepc       <= c.mepc;
            ctrl_mstatus_wr <= c.mstatus_wr;
            ctrl_mstatus    <= c.mstatus;
            @(negedge aclk);
            check_bit("rd_wr_en", rd_wr_en, 1'b1);
            check_word("rd_wr_addr", xlen_t'(rd_wr_addr), xlen_t'(c.rd));
            check_word("rd_wr_val", rd_wr_val, c.exp_rd);
            @(posedge aclk);
            ctrl_mepc_wr    <= 1'b0;
            ctrl_mstatus_wr <= 1'b0;
            wait_ready();
            check_bit("rd_wr_en", rd_wr_en, 1'b0);  // Single-cycle pulse
        end
        check_sb("csr_sb", csr_sb, c.exp_sb);
        $display("case %0d %s csr %h: %s", idx, c.op.name(), c.csr,
                 (errors == err_before) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        aclk            = 1'b0;
        aresetn         = 1'b0;
        valid           = 1'b0;
        instbus         = '0;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mepc       = '0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mstatus    = '0;
        rs1_file        = '{default: '0};
        errors          = 0;
        checks          = 0;
        load_cases();

        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        label = "reset";
        check_bit("ready", ready, 1'b1);
        check_bit("rd_wr_en", rd_wr_en, 1'b0);
        check_bit("ro_trap", ro_trap, 1'b0);
        check_sb("csr_sb", csr_sb, '0);
        $display("reset: %s", (errors == 0) ? "ok" : "FAILED");

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        $display("summary: %0d cases, %0d checks, %0d errors", NUM_CASES, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
